/* src/xm_pkg.sv */
// shared types, register map and timer constants of the host register block
`default_nettype none

package xm_pkg;

    typedef logic [15:0] word_t;            // register or memory word
    typedef logic [15:0] addr_t;            // vram or xr address
    typedef logic [7:0]  byte_t;            // host bus byte
    typedef logic [6:0]  intr_t;            // interrupt vector

    // host visible register numbers, 12..15 read as zero
    typedef enum logic [3:0] {
        XM_SYS_CTRL = 4'h0,                 // busy, nibble write mask
        XM_INT_CTRL = 4'h1,                 // intr mask, status, clear
        XM_TIMER    = 4'h2,                 // tenth ms timer
        XM_RD_XADDR = 4'h3,                 // xr read address
        XM_WR_XADDR = 4'h4,                 // xr write address
        XM_XDATA    = 4'h5,                 // xr data port
        XM_RD_INCR  = 4'h6,                 // vram read increment
        XM_RD_ADDR  = 4'h7,                 // vram read address
        XM_WR_INCR  = 4'h8,                 // vram write increment
        XM_WR_ADDR  = 4'h9,                 // vram write address
        XM_DATA     = 4'hA,                 // vram data port
        XM_DATA_2   = 4'hB                  // second vram data port
    } xm_reg_e;

    // one synchronised bus access
    typedef struct packed {
        logic    wr_stb;                    // one cycle write strobe
        logic    rd_stb;                    // one cycle read strobe
        xm_reg_e reg_num;                   // held until next access
        logic    bytesel;                   // 0 even (high) byte, 1 odd
        byte_t   data;                      // write byte
    } bus_req_t;

    // vram / xr request, held until ack
    typedef struct packed {
        logic       vram_sel;
        logic       xr_sel;
        logic       wr;                     // 1 write, 0 read
        logic [3:0] wrmask;                 // nibble enables, vram only
        addr_t      addr;
        word_t      data;
    } mem_req_t;

    // readable access state
    typedef struct packed {
        addr_t rd_xaddr;
        addr_t wr_xaddr;
        word_t rd_incr;
        addr_t rd_addr;
        word_t wr_incr;
        addr_t wr_addr;
        word_t vram_rdata;                  // prefetched vram word
        word_t xr_rdata;                    // prefetched xr word
        logic  busy;                        // request or step in flight
    } xm_ptrs_t;

    localparam logic       CS_ACTIVE    = 1'b0;     // chip select low active
    localparam logic [3:0] WRMASK_RESET = 4'b1111;  // all nibbles written

    // 10 kHz from 25.125 MHz pixel clock, reduced fraction 2/5025
    localparam int TIMER_CLK_REDUCED = 5025;
    localparam int TIMER_HZ_REDUCED  = 2;
    localparam int TIMER_FRAC_W      = $clog2(TIMER_CLK_REDUCED) + 1;

endpackage

`default_nettype wire

/* src/bus_strobe_sync.sv */
// chip select synchroniser, falling edge detect and bus field capture
`default_nettype none

module bus_strobe_sync (
    input  wire logic        clk,
    input  wire logic        reset_i,
    input  wire logic        bus_cs_n_i,        // async chip select
    input  wire logic        bus_rd_nwr_i,      // 1 read, 0 write
    input  wire logic [3:0]  bus_reg_num_i,     // register number
    input  wire logic        bus_bytesel_i,     // 0 even, 1 odd
    input  wire logic [7:0]  bus_data_i,        // write byte
    output xm_pkg::bus_req_t bus_req_o          // strobes and captured fields
);
    import xm_pkg::*;

    logic [1:0] cs_sync;                        // two flop synchroniser
    logic       cs_prev;                        // previous synced level
    logic       cs_fall;                        // access begins
    logic       wr_stb;
    logic       rd_stb;
    xm_reg_e    reg_num;
    logic       bytesel;
    byte_t      data;

    assign cs_fall = (cs_sync[1] == CS_ACTIVE) && (cs_prev != CS_ACTIVE);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            cs_sync <= {2{~CS_ACTIVE}};         // start deselected
            cs_prev <= ~CS_ACTIVE;
            wr_stb  <= 1'b0;
            rd_stb  <= 1'b0;
        end else begin
            cs_sync <= {cs_sync[0], bus_cs_n_i};
            cs_prev <= cs_sync[1];
            wr_stb  <= cs_fall && !bus_rd_nwr_i; // one strobe per access
            rd_stb  <= cs_fall && bus_rd_nwr_i;
        end
    end

    // host holds fields stable while selected, so sample raw
    always_ff @(posedge clk) begin
        if (cs_fall) begin
            reg_num <= xm_reg_e'(bus_reg_num_i);
            bytesel <= bus_bytesel_i;
            data    <= bus_data_i;
        end
    end

    always_comb begin
        bus_req_o.wr_stb  = wr_stb;
        bus_req_o.rd_stb  = rd_stb;
        bus_req_o.reg_num = reg_num;            // stays valid for read mux
        bus_req_o.bytesel = bytesel;
        bus_req_o.data    = data;
    end

endmodule

`default_nettype wire

/* src/tenth_ms_timer.sv */
// tenth millisecond timer, fractional clock divider and tick counter
`default_nettype none

module tenth_ms_timer (
    input  wire logic     clk,
    input  wire logic     reset_i,
    output xm_pkg::word_t timer_o               // free running tick count
);
    import xm_pkg::*;

    logic [TIMER_FRAC_W-1:0] frac;              // fractional accumulator
    logic                    tick;

    assign tick = !frac[TIMER_FRAC_W-1];        // top bit clear, time to step

    always_ff @(posedge clk) begin
        if (reset_i) begin
            frac    <= '0;
            timer_o <= '0;
        end else if (tick) begin
            // add hz and take back the clock count in one step
            frac    <= frac + TIMER_FRAC_W'(TIMER_HZ_REDUCED - TIMER_CLK_REDUCED);
            timer_o <= timer_o + 1'b1;
        end else begin
            frac    <= frac + TIMER_FRAC_W'(TIMER_HZ_REDUCED);
        end
    end

endmodule

`default_nettype wire

/* src/xm_access_ctrl.sv */
// vram and xr address registers, request issue, ack handling and prefetch
`default_nettype none

module xm_access_ctrl (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire xm_pkg::bus_req_t bus_req_i,    // synced bus access
    input  wire logic [3:0]       wrmask_i,     // current nibble mask
    output xm_pkg::mem_req_t      mem_req_o,    // held until ack
    input  wire logic             vram_ack_i,
    input  wire logic             xr_ack_i,
    input  wire xm_pkg::word_t    vram_data_i,
    input  wire xm_pkg::word_t    xr_data_i,
    output xm_pkg::xm_ptrs_t      ptrs_o        // readable state
);
    import xm_pkg::*;

    addr_t      rd_xaddr;
    addr_t      wr_xaddr;
    word_t      rd_incr;
    addr_t      rd_addr;
    word_t      wr_incr;
    addr_t      wr_addr;
    byte_t      data_even;                      // DATA high byte hold
    byte_t      xdata_even;                     // XDATA high byte hold
    word_t      vram_rdata;
    word_t      xr_rdata;

    logic       vram_sel;
    logic       xr_sel;
    logic       mem_wr;
    logic [3:0] mem_wrmask;
    addr_t      mem_addr;
    word_t      mem_wdata;

    logic       rd_step;                        // pointer steps after ack
    logic       wr_step;
    logic       xrd_step;
    logic       xwr_step;

    logic       odd_wr;
    logic       odd_rd;
    logic       is_data;
    logic       vram_rd_go;
    logic       vram_wr_go;
    logic       xr_rd_go;
    logic       xr_wr_go;
    logic       vram_done;
    logic       xr_done;

    // write one byte of a word, even byte is the high one
    function automatic word_t put_byte(input word_t cur, input logic odd, input byte_t b);
        return odd ? {cur[15:8], b} : {b, cur[7:0]};
    endfunction

    assign odd_wr     = bus_req_i.wr_stb && bus_req_i.bytesel;
    assign odd_rd     = bus_req_i.rd_stb && bus_req_i.bytesel;
    assign is_data    = (bus_req_i.reg_num == XM_DATA) || (bus_req_i.reg_num == XM_DATA_2);
    assign vram_rd_go = (odd_wr && bus_req_i.reg_num == XM_RD_ADDR) || (odd_rd && is_data);
    assign vram_wr_go = odd_wr && is_data;
    assign xr_rd_go   = (odd_wr && bus_req_i.reg_num == XM_RD_XADDR)
                     || (odd_rd && bus_req_i.reg_num == XM_XDATA);
    assign xr_wr_go   = odd_wr && bus_req_i.reg_num == XM_XDATA;
    assign vram_done  = vram_sel && vram_ack_i;
    assign xr_done    = xr_sel && xr_ack_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vram_sel <= 1'b0;
            xr_sel   <= 1'b0;
            mem_wr   <= 1'b0;
            rd_step  <= 1'b0;
            wr_step  <= 1'b0;
            xrd_step <= 1'b0;
            xwr_step <= 1'b0;
            rd_xaddr <= '0;
            wr_xaddr <= '0;
            rd_incr  <= '0;
            rd_addr  <= '0;
            wr_incr  <= '0;
            wr_addr  <= '0;
        end else begin
            rd_step  <= vram_done && !mem_wr;   // step one cycle after ack
            wr_step  <= vram_done && mem_wr;
            xrd_step <= xr_done && !mem_wr;
            xwr_step <= xr_done && mem_wr;
            if (vram_done || xr_done) begin
                vram_sel <= 1'b0;
                xr_sel   <= 1'b0;
                mem_wr   <= 1'b0;
            end

            if (rd_step) rd_addr <= rd_addr + rd_incr;
            if (wr_step) wr_addr <= wr_addr + wr_incr;
            if (xrd_step) rd_xaddr <= rd_xaddr + 1'b1;  // xr always by one
            if (xwr_step) wr_xaddr <= wr_xaddr + 1'b1;

            if (bus_req_i.wr_stb) begin
                case (bus_req_i.reg_num)
                    XM_RD_XADDR: rd_xaddr <= put_byte(rd_xaddr, bus_req_i.bytesel, bus_req_i.data);
                    XM_WR_XADDR: wr_xaddr <= put_byte(wr_xaddr, bus_req_i.bytesel, bus_req_i.data);
                    XM_RD_INCR:  rd_incr  <= put_byte(rd_incr, bus_req_i.bytesel, bus_req_i.data);
                    XM_RD_ADDR:  rd_addr  <= put_byte(rd_addr, bus_req_i.bytesel, bus_req_i.data);
                    XM_WR_INCR:  wr_incr  <= put_byte(wr_incr, bus_req_i.bytesel, bus_req_i.data);
                    XM_WR_ADDR:  wr_addr  <= put_byte(wr_addr, bus_req_i.bytesel, bus_req_i.data);
                    default: begin
                    end
                endcase
            end

            // host waits for busy low, so never overlaps a request
            if (vram_rd_go || vram_wr_go) vram_sel <= 1'b1;
            if (xr_rd_go || xr_wr_go) xr_sel <= 1'b1;
            if (vram_rd_go || vram_wr_go || xr_rd_go || xr_wr_go) begin
                mem_wr <= vram_wr_go || xr_wr_go;
            end
        end
    end

    // request payload, holds and prefetched words
    always_ff @(posedge clk) begin
        if (vram_done && !mem_wr) vram_rdata <= vram_data_i;
        if (xr_done && !mem_wr) xr_rdata <= xr_data_i;
        if (bus_req_i.wr_stb && !bus_req_i.bytesel) begin
            if (is_data) data_even <= bus_req_i.data;
            if (bus_req_i.reg_num == XM_XDATA) xdata_even <= bus_req_i.data;
        end
        if (vram_rd_go) begin
            // new low byte on RD_ADDR write, stepped address on DATA read
            mem_addr <= bus_req_i.wr_stb ? {rd_addr[15:8], bus_req_i.data} : rd_addr;
        end
        if (xr_rd_go) begin
            mem_addr <= bus_req_i.wr_stb ? {rd_xaddr[15:8], bus_req_i.data} : rd_xaddr;
        end
        if (vram_wr_go) begin
            mem_addr   <= wr_addr;
            mem_wdata  <= {data_even, bus_req_i.data};
            mem_wrmask <= wrmask_i;             // mask at issue time
        end
        if (xr_wr_go) begin
            mem_addr   <= wr_xaddr;
            mem_wdata  <= {xdata_even, bus_req_i.data};
            mem_wrmask <= 4'b1111;              // xr writes whole word
        end
    end

    always_comb begin
        mem_req_o.vram_sel = vram_sel;
        mem_req_o.xr_sel   = xr_sel;
        mem_req_o.wr       = mem_wr;
        mem_req_o.wrmask   = mem_wrmask;
        mem_req_o.addr     = mem_addr;
        mem_req_o.data     = mem_wdata;

        ptrs_o.rd_xaddr    = rd_xaddr;
        ptrs_o.wr_xaddr    = wr_xaddr;
        ptrs_o.rd_incr     = rd_incr;
        ptrs_o.rd_addr     = rd_addr;
        ptrs_o.wr_incr     = wr_incr;
        ptrs_o.wr_addr     = wr_addr;
        ptrs_o.vram_rdata  = vram_rdata;
        ptrs_o.xr_rdata    = xr_rdata;
        ptrs_o.busy        = vram_sel || xr_sel || rd_step || wr_step || xrd_step || xwr_step;
    end

endmodule

`default_nettype wire

/* src/xm_ctrl_regs.sv */
// SYS_CTRL, INT_CTRL and timer latch registers, bus read mux
`default_nettype none

module xm_ctrl_regs (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire xm_pkg::bus_req_t bus_req_i,    // synced bus access
    input  wire xm_pkg::xm_ptrs_t ptrs_i,       // access state to read back
    input  wire xm_pkg::word_t    timer_i,      // live timer
    input  wire xm_pkg::intr_t    intr_status_i,
    output logic [3:0]            wrmask_o,     // vram nibble mask
    output xm_pkg::intr_t         intr_mask_o,
    output xm_pkg::intr_t         intr_clear_o, // one cycle clear strobe
    output xm_pkg::byte_t         bus_data_o
);
    import xm_pkg::*;

    byte_t timer_lo;                            // low byte frozen on even read
    word_t rd_word;                             // selected register word

    always_ff @(posedge clk) begin
        if (reset_i) begin
            wrmask_o     <= WRMASK_RESET;
            intr_mask_o  <= '0;
            intr_clear_o <= '0;
        end else begin
            intr_clear_o <= '0;                 // pulse only
            if (bus_req_i.wr_stb) begin
                case (bus_req_i.reg_num)
                    XM_SYS_CTRL: begin
                        if (bus_req_i.bytesel) wrmask_o <= bus_req_i.data[3:0];
                    end
                    XM_INT_CTRL: begin
                        if (bus_req_i.bytesel) begin
                            intr_clear_o <= bus_req_i.data[6:0];
                        end else begin
                            intr_mask_o  <= bus_req_i.data[6:0];
                        end
                    end
                    default: begin
                    end
                endcase
            end
        end
    end

    // even read of any register, so high then low timer bytes pair up
    always_ff @(posedge clk) begin
        if (bus_req_i.rd_stb && !bus_req_i.bytesel) timer_lo <= timer_i[7:0];
    end

    always_comb begin
        case (bus_req_i.reg_num)
            XM_SYS_CTRL: rd_word = {ptrs_i.busy, 11'b0, wrmask_o};
            XM_INT_CTRL: rd_word = {1'b0, intr_mask_o, 1'b0, intr_status_i};
            XM_TIMER:    rd_word = {timer_i[15:8], timer_lo};   // high byte live
            XM_RD_XADDR: rd_word = ptrs_i.rd_xaddr;
            XM_WR_XADDR: rd_word = ptrs_i.wr_xaddr;
            XM_XDATA:    rd_word = ptrs_i.xr_rdata;
            XM_RD_INCR:  rd_word = ptrs_i.rd_incr;
            XM_RD_ADDR:  rd_word = ptrs_i.rd_addr;
            XM_WR_INCR:  rd_word = ptrs_i.wr_incr;
            XM_WR_ADDR:  rd_word = ptrs_i.wr_addr;
            XM_DATA,
            XM_DATA_2:   rd_word = ptrs_i.vram_rdata;
            default:     rd_word = '0;          // 12..15 unused
        endcase
        bus_data_o = bus_req_i.bytesel ? rd_word[7:0] : rd_word[15:8];
    end

endmodule

`default_nettype wire

/* src/xm_regs_top.sv */
// host register block top, bus sync, timer, access control and control regs
`default_nettype none

module xm_regs_top (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          bus_cs_n_i,      // chip select, low active
    input  wire logic          bus_rd_nwr_i,    // 1 read, 0 write
    input  wire logic [3:0]    bus_reg_num_i,   // register number
    input  wire logic          bus_bytesel_i,   // 0 even, 1 odd
    input  wire logic [7:0]    bus_data_i,
    output xm_pkg::byte_t      bus_data_o,
    output xm_pkg::mem_req_t   mem_req_o,       // vram / xr request
    input  wire logic          vram_ack_i,
    input  wire logic          xr_ack_i,
    input  wire xm_pkg::word_t vram_data_i,
    input  wire xm_pkg::word_t xr_data_i,
    input  wire xm_pkg::intr_t intr_status_i,
    output xm_pkg::intr_t      intr_mask_o,
    output xm_pkg::intr_t      intr_clear_o
);
    import xm_pkg::*;

    bus_req_t   bus_req;                        // strobes to both decoders
    xm_ptrs_t   ptrs;
    word_t      timer;
    logic [3:0] wrmask;

    bus_strobe_sync bus_strobe_sync_i (
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_cs_n_i    (bus_cs_n_i),
        .bus_rd_nwr_i  (bus_rd_nwr_i),
        .bus_reg_num_i (bus_reg_num_i),
        .bus_bytesel_i (bus_bytesel_i),
        .bus_data_i    (bus_data_i),
        .bus_req_o     (bus_req)
    );

    tenth_ms_timer tenth_ms_timer_i (
        .clk     (clk),
        .reset_i (reset_i),
        .timer_o (timer)
    );

    xm_access_ctrl xm_access_ctrl_i (           // registers 3..11
        .clk         (clk),
        .reset_i     (reset_i),
        .bus_req_i   (bus_req),
        .wrmask_i    (wrmask),
        .mem_req_o   (mem_req_o),
        .vram_ack_i  (vram_ack_i),
        .xr_ack_i    (xr_ack_i),
        .vram_data_i (vram_data_i),
        .xr_data_i   (xr_data_i),
        .ptrs_o      (ptrs)
    );

    xm_ctrl_regs xm_ctrl_regs_i (               // registers 0..2 and read mux
        .clk           (clk),
        .reset_i       (reset_i),
        .bus_req_i     (bus_req),
        .ptrs_i        (ptrs),
        .timer_i       (timer),
        .intr_status_i (intr_status_i),
        .wrmask_o      (wrmask),
        .intr_mask_o   (intr_mask_o),
        .intr_clear_o  (intr_clear_o),
        .bus_data_o    (bus_data_o)
    );

endmodule

`default_nettype wire

/* sim/tb_mem_model.sv */
// VRAM and XR memory responder, random ack delay of 1 to 4 cycles
`default_nettype none

module tb_mem_model (
    input  wire logic             clk,
    input  wire logic             reset_i,
    input  wire xm_pkg::mem_req_t mem_req_i,    // held until ack
    output logic                  vram_ack_o,
    output logic                  xr_ack_o,
    output xm_pkg::word_t         vram_data_o,
    output xm_pkg::word_t         xr_data_o
);
    timeunit 1ns;
    timeprecision 1ps;
    import xm_pkg::*;

    word_t      vram [256];                     // low address bits only
    word_t      xr [256];
    integer     seed = 32'h9e3e3121;
    logic       serving;                        // request taken, ack pending
    int         wait_cnt;
    logic [7:0] idx;
    word_t      nib_en;                         // mask bits widened to nibbles

    assign idx    = mem_req_i.addr[7:0];
    assign nib_en = {{4{mem_req_i.wrmask[3]}}, {4{mem_req_i.wrmask[2]}},
                     {4{mem_req_i.wrmask[1]}}, {4{mem_req_i.wrmask[0]}}};

    initial begin
        for (int i = 0; i < 256; i++) begin
            vram[i] = {8'(i) ^ 8'hc3, ~8'(i)};  // preload, every index distinct
            xr[i]   = {8'(i) ^ 8'h96, 8'(i)};
        end
    end

    always @(posedge clk) begin
        vram_ack_o <= 1'b0;                     // ack lasts one cycle
        xr_ack_o   <= 1'b0;
        if (reset_i) begin
            serving <= 1'b0;
        end else if (!serving && !vram_ack_o && !xr_ack_o
                     && (mem_req_i.vram_sel || mem_req_i.xr_sel)) begin
            serving  <= 1'b1;
            wait_cnt <= 1 + int'($unsigned($random(seed)) % 4);
        end else if (serving && wait_cnt > 1) begin
            wait_cnt <= wait_cnt - 1;
        end else if (serving) begin
            serving <= 1'b0;
            if (mem_req_i.vram_sel) begin
                vram_ack_o  <= 1'b1;
                vram_data_o <= vram[idx];
                if (mem_req_i.wr) vram[idx] <= (vram[idx] & ~nib_en) | (mem_req_i.data & nib_en);
            end else begin
                xr_ack_o  <= 1'b1;
                xr_data_o <= xr[idx];
                if (mem_req_i.wr) xr[idx] <= mem_req_i.data;   // whole word
            end
        end
    end

endmodule

`default_nettype wire

/* sim/tb_xm_regs.sv */
// testbench of the host register block, bus tasks, shadow model and checks
`default_nettype none

module tb_xm_regs;
    timeunit 1ns;
    timeprecision 1ps;
    import xm_pkg::*;

    // ~220 accesses of 10 cycles with polls, plus the 6000 cycle timer gap
    localparam int CYCLE_LIMIT = 20000;
    localparam int TIMER_GAP   = 6000;

    logic       clk = 1'b0;
    logic       reset_i;
    logic       bus_cs_n;
    logic       bus_rd_nwr;
    logic [3:0] bus_reg_num;
    logic       bus_bytesel;
    byte_t      bus_wdata;
    byte_t      bus_rdata;
    mem_req_t   mem_req;
    logic       vram_ack;
    logic       xr_ack;
    word_t      vram_data;
    word_t      xr_data;
    intr_t      intr_status;
    intr_t      intr_mask;
    intr_t      intr_clear;
    int         cycles = 0;
    int         clear_pulses = 0;               // cycles with clear nonzero
    intr_t      last_clear;
    integer     seed = 32'h9e3e3121;
    word_t      sh_reg [16];                    // shadow pointers by reg number
    word_t      sh_vram [256];
    word_t      sh_xr [256];
    word_t      sh_vdata, sh_xdata;             // shadow prefetch words
    logic [3:0] sh_mask;
    intr_t      sh_imask;

    xm_regs_top xm_regs_top_i (
        .clk (clk), .reset_i (reset_i),
        .bus_cs_n_i (bus_cs_n), .bus_rd_nwr_i (bus_rd_nwr), .bus_reg_num_i (bus_reg_num),
        .bus_bytesel_i (bus_bytesel), .bus_data_i (bus_wdata), .bus_data_o (bus_rdata),
        .mem_req_o (mem_req), .vram_ack_i (vram_ack), .xr_ack_i (xr_ack),
        .vram_data_i (vram_data), .xr_data_i (xr_data), .intr_status_i (intr_status),
        .intr_mask_o (intr_mask), .intr_clear_o (intr_clear)
    );

    tb_mem_model mem_model_i (
        .clk (clk), .reset_i (reset_i), .mem_req_i (mem_req),
        .vram_ack_o (vram_ack), .xr_ack_o (xr_ack),
        .vram_data_o (vram_data), .xr_data_o (xr_data)
    );

    always #4 clk = ~clk;                       // 8 ns period

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the run went past %0d cycles without finishing", CYCLE_LIMIT);
            $display("Something failed");
            $fatal(1, "run stopped by the cycle limit");
        end
    end

    always @(negedge clk) begin
        if (intr_clear != '0) begin
            clear_pulses <= clear_pulses + 1;
            last_clear   <= intr_clear;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            $display("Something failed");
            $fatal(1, "stopped at the first error");
        end
    endtask

    // one host access, cs low 6 cycles and high 4
    task automatic bus_access(input logic rd, input logic [3:0] num, input logic odd,
                              input byte_t wdata, output byte_t rdata);
        @(posedge clk);
        bus_cs_n    <= CS_ACTIVE;
        bus_rd_nwr  <= rd;
        bus_reg_num <= num;
        bus_bytesel <= odd;
        bus_wdata   <= wdata;
        repeat (4) @(posedge clk);              // strobe after third edge
        @(negedge clk);
        rdata = bus_rdata;                      // before a prefetch can land
        repeat (2) @(posedge clk);
        bus_cs_n <= ~CS_ACTIVE;
        repeat (3) @(posedge clk);
    endtask

    task automatic wait_idle();
        byte_t b;
        b = 8'h80;
        while (b[7]) bus_access(1'b1, XM_SYS_CTRL, 1'b0, 8'h00, b);   // busy is bit 15
    endtask

    function automatic word_t apply_mask(input word_t old, input word_t nw, input logic [3:0] m);
        word_t r;
        r = old;
        for (int n = 0; n < 4; n++) begin
            if (m[n]) r[4*n +: 4] = nw[4*n +: 4];
        end
        return r;
    endfunction

    // expected readback byte from the shadow state
    function automatic byte_t expect_byte(input logic [3:0] num, input logic odd);
        word_t w;
        case (num)
            XM_SYS_CTRL:        w = {12'h000, sh_mask};     // sampled while idle
            XM_INT_CTRL:        w = {1'b0, sh_imask, 1'b0, intr_status};
            XM_XDATA:           w = sh_xdata;
            XM_DATA, XM_DATA_2: w = sh_vdata;
            default:            w = sh_reg[num];            // 12..15 stay zero
        endcase
        return odd ? w[7:0] : w[15:8];
    endfunction

    task automatic write_reg(input logic [3:0] num, input word_t w);
        byte_t dummy;
        bus_access(1'b0, num, 1'b0, w[15:8], dummy);
        bus_access(1'b0, num, 1'b1, w[7:0], dummy);
        case (num)
            XM_RD_XADDR: begin
                sh_xdata = sh_xr[w[7:0]];
                sh_reg[XM_RD_XADDR] = w + 16'd1;
            end
            XM_RD_ADDR: begin
                sh_vdata = sh_vram[w[7:0]];
                sh_reg[XM_RD_ADDR] = w + sh_reg[XM_RD_INCR];
            end
            XM_XDATA: begin
                sh_xr[sh_reg[XM_WR_XADDR][7:0]] = w;
                sh_reg[XM_WR_XADDR] += 16'd1;
            end
            XM_DATA, XM_DATA_2: begin
                sh_vram[sh_reg[XM_WR_ADDR][7:0]] =
                    apply_mask(sh_vram[sh_reg[XM_WR_ADDR][7:0]], w, sh_mask);
                sh_reg[XM_WR_ADDR] += sh_reg[XM_WR_INCR];
            end
            default: sh_reg[num] = w;
        endcase
        wait_idle();
    endtask

    task automatic check_reg(input logic [3:0] num, input string name);
        byte_t hi, lo;
        word_t exp;
        bus_access(1'b1, num, 1'b0, 8'h00, hi);
        bus_access(1'b1, num, 1'b1, 8'h00, lo);
        exp = {expect_byte(num, 1'b0), expect_byte(num, 1'b1)};
        check_value(name, {hi, lo}, exp);
        case (num)
            XM_XDATA: begin                     // odd read fetches next word
                sh_xdata = sh_xr[sh_reg[XM_RD_XADDR][7:0]];
                sh_reg[XM_RD_XADDR] += 16'd1;
            end
            XM_DATA, XM_DATA_2: begin
                sh_vdata = sh_vram[sh_reg[XM_RD_ADDR][7:0]];
                sh_reg[XM_RD_ADDR] += sh_reg[XM_RD_INCR];
            end
            default: begin
            end
        endcase
        wait_idle();
    endtask

    initial begin
        word_t w, t1, t2;
        byte_t dummy, hi, lo, lo_held;
        int    idx, pulses_before, at1, at2, exp_ticks, got_ticks;
        bus_cs_n    = ~CS_ACTIVE;
        bus_rd_nwr  = 1'b1;
        bus_reg_num = '0;
        bus_bytesel = 1'b0;
        bus_wdata   = '0;
        intr_status = 7'h35;
        reset_i     = 1'b1;
        sh_vdata    = '0;
        sh_xdata    = '0;
        sh_mask     = WRMASK_RESET;
        sh_imask    = '0;
        for (int i = 0; i < 16; i++) sh_reg[i] = '0;
        for (int i = 0; i < 256; i++) begin
            sh_vram[i] = {8'(i) ^ 8'hc3, ~8'(i)};
            sh_xr[i]   = {8'(i) ^ 8'h96, 8'(i)};
        end
        repeat (8) @(posedge clk);
        reset_i <= 1'b0;
        check_reg(XM_SYS_CTRL, "sys_ctrl_reset");
        check_reg(XM_WR_ADDR, "wr_addr_reset");

        // pointer, mask and INT_CTRL readback
        write_reg(XM_RD_INCR, 16'h0002);
        write_reg(XM_WR_INCR, 16'h0101);
        write_reg(XM_WR_ADDR, 16'h1234);
        write_reg(XM_WR_XADDR, 16'h4321);
        write_reg(XM_RD_XADDR, 16'h0a0b);       // prefetch steps it by one
        write_reg(XM_RD_ADDR, 16'h5678);        // steps by rd_incr
        check_reg(XM_RD_INCR, "rd_incr");
        check_reg(XM_WR_INCR, "wr_incr");
        check_reg(XM_WR_ADDR, "wr_addr");
        check_reg(XM_WR_XADDR, "wr_xaddr");
        check_reg(XM_RD_XADDR, "rd_xaddr");
        check_reg(XM_RD_ADDR, "rd_addr");
        check_reg(4'd13, "unused_reg");
        bus_access(1'b0, XM_SYS_CTRL, 1'b1, 8'h09, dummy);
        sh_mask = 4'h9;
        check_reg(XM_SYS_CTRL, "sys_ctrl");
        bus_access(1'b0, XM_INT_CTRL, 1'b0, 8'h2a, dummy);
        sh_imask = 7'h2a;
        check_value("intr_mask_o", intr_mask, sh_imask);
        @(posedge clk);
        intr_status <= 7'h4c;
        check_reg(XM_INT_CTRL, "int_ctrl");

        // VRAM writes through WR_ADDR under a partial mask
        bus_access(1'b0, XM_SYS_CTRL, 1'b1, 8'h0d, dummy);
        sh_mask = 4'b1101;
        write_reg(XM_WR_INCR, 16'h0003);
        write_reg(XM_WR_ADDR, 16'h0120);
        for (int k = 0; k < 8; k++) begin
            w   = word_t'($random(seed));
            idx = sh_reg[XM_WR_ADDR][7:0];
            write_reg(k[0] ? XM_DATA_2 : XM_DATA, w);
            check_value("vram_word", mem_model_i.vram[idx], sh_vram[idx]);
        end
        bus_access(1'b1, XM_WR_ADDR, 1'b0, 8'h00, hi);
        bus_access(1'b1, XM_WR_ADDR, 1'b1, 8'h00, lo);
        check_value("wr_addr_end", {hi, lo}, 16'h0120 + 16'd8 * 16'h0003);
        check_reg(XM_WR_ADDR, "wr_addr_after");

        // VRAM reads with prefetch
        write_reg(XM_RD_INCR, 16'h0005);
        write_reg(XM_RD_ADDR, 16'h0210);
        for (int k = 0; k < 8; k++) check_reg(XM_DATA, "vram_read");

        // XR writes then reads at consecutive addresses
        write_reg(XM_WR_XADDR, 16'h0040);
        for (int k = 0; k < 4; k++) begin
            w   = word_t'($random(seed));
            idx = sh_reg[XM_WR_XADDR][7:0];
            write_reg(XM_XDATA, w);
            check_value("xr_word", mem_model_i.xr[idx], sh_xr[idx]);
        end
        write_reg(XM_RD_XADDR, 16'h0040);
        for (int k = 0; k < 6; k++) check_reg(XM_XDATA, "xr_read");
        check_reg(XM_WR_XADDR, "wr_xaddr_after");

        // interrupt clear pulse and mask output
        pulses_before = clear_pulses;
        bus_access(1'b0, XM_INT_CTRL, 1'b1, 8'h55, dummy);
        check_value("intr_clear_pulses", clear_pulses - pulses_before, 1);
        check_value("intr_clear_o", last_clear, 7'h55);
        check_value("intr_mask_o", intr_mask, sh_imask);   // odd byte leaves mask alone
        bus_access(1'b0, XM_INT_CTRL, 1'b0, 8'h13, dummy);
        sh_imask = 7'h13;
        check_value("intr_mask_o", intr_mask, sh_imask);

        // timer rate and low byte latch
        at1 = cycles;
        bus_access(1'b1, XM_TIMER, 1'b0, 8'h00, hi);
        bus_access(1'b1, XM_TIMER, 1'b1, 8'h00, lo);
        t1 = {hi, lo};
        repeat (TIMER_GAP) @(posedge clk);      // a couple of ticks go by
        bus_access(1'b1, XM_TIMER, 1'b1, 8'h00, lo_held);
        check_value("timer_lo_latch", lo_held, lo);
        at2 = cycles;
        bus_access(1'b1, XM_TIMER, 1'b0, 8'h00, hi);
        bus_access(1'b1, XM_TIMER, 1'b1, 8'h00, lo);
        t2 = {hi, lo};
        exp_ticks = (at2 - at1) * TIMER_HZ_REDUCED / TIMER_CLK_REDUCED;
        got_ticks = int'(t2 - t1);
        if (got_ticks == exp_ticks + 1 || got_ticks + 1 == exp_ticks) begin
            exp_ticks = got_ticks;              // divider phase, one tick either way
        end
        check_value("timer_ticks", got_ticks, exp_ticks);

        $display("Everything OK");
        $finish;
    end

endmodule

`default_nettype wire

/* xm_regs_top.f */
src/xm_pkg.sv
src/bus_strobe_sync.sv
src/tenth_ms_timer.sv
src/xm_access_ctrl.sv
src/xm_ctrl_regs.sv
src/xm_regs_top.sv
sim/tb_mem_model.sv
sim/tb_xm_regs.sv

/* run_sim.sh */
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal --top-module tb_xm_regs \
    -f xm_regs_top.f -o tb_xm_regs || { echo "build failed"; exit 1; }
./obj_dir/tb_xm_regs > sim.log 2>&1
cat sim.log
grep -q "Something failed" sim.log && { echo "simulation failed"; exit 1; }
grep -q "Everything OK" sim.log || { echo "simulation did not finish"; exit 1; }
echo "simulation passed"
